// ==== adc_capture_top.f ====
+incdir+common
common/adc_capture_pkg.sv
adc_unit/adc_frame_align.sv
adc_unit/adc_gearbox.sv
rtl/sample_fifo.sv
rtl/adc_reg_attach.sv
rtl/adc_capture_top.sv
test/adc_capture_sva.sv
test/adc_capture_checker.sv
test/adc_capture_tb.sv

// ==== adc_unit/adc_frame_align.sv ====
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_frame_align (
  input  logic                    fclk,
  input  logic                    rst,
  input  logic [3:0]              frame_i,
  input  logic                    realign_i,
  input  logic                    err_clr_i,
  output adc_capture_pkg::phase_t phase_o,
  output logic                    locked_o,
  output logic [31:0]             err_cnt_o
);

  localparam int MATCH_W = $clog2(`ADC_LOCK_CNT + 1);

  adc_capture_pkg::phase_t phase_q;
  logic [MATCH_W-1:0]      match_cnt;
  logic [1:0]              miss_cnt;
  logic [3:0]              expected;
  logic                    match;

  // Add n bits to a frame position, modulo the frame length
  function automatic adc_capture_pkg::phase_t phase_add(
    input adc_capture_pkg::phase_t p,
    input int unsigned             n
  );
    int unsigned s;
    s = p + n;
    if (s >= `ADC_FRAME_BITS) begin
      s = s - `ADC_FRAME_BITS;
    end
    return adc_capture_pkg::phase_t'(s);
  endfunction

  // Marker expected in a nibble whose first bit sits at position p
  function automatic logic [3:0] marker_pattern(input adc_capture_pkg::phase_t p);
    logic [3:0] pat;
    for (int k = 0; k < 4; k++) begin
      pat[3-k] = (phase_add(p, k) == '0);
    end
    return pat;
  endfunction

  assign expected = marker_pattern(phase_q);
  assign match    = (frame_i == expected);
  assign phase_o  = phase_q;

  always_ff @(posedge fclk) begin
    if (rst) begin
      phase_q   <= '0;
      match_cnt <= '0;
      miss_cnt  <= '0;
      locked_o  <= 1'b0;
    end else if (realign_i) begin
      phase_q   <= phase_add(phase_q, 4);
      match_cnt <= '0;
      miss_cnt  <= '0;
      locked_o  <= 1'b0;
    end else if (!locked_o) begin
      miss_cnt <= '0;
      if (match) begin
        phase_q <= phase_add(phase_q, 4);
        if (match_cnt == MATCH_W'(`ADC_LOCK_CNT - 1)) begin
          locked_o  <= 1'b1;
          match_cnt <= '0;
        end else begin
          match_cnt <= match_cnt + 1'b1;
        end
      end else begin
        // Hunting: four bits plus a one-bit slip is a full frame, so hold
        phase_q   <= phase_q;
        match_cnt <= '0;
      end
    end else begin
      phase_q <= phase_add(phase_q, 4);
      if (match) begin
        miss_cnt <= '0;
      end else if (miss_cnt == 2'd2) begin
        locked_o <= 1'b0;
        miss_cnt <= '0;
      end else begin
        miss_cnt <= miss_cnt + 1'b1;
      end
    end
  end

  // Frame errors only count while locked
  always_ff @(posedge fclk) begin
    if (rst || err_clr_i) begin
      err_cnt_o <= '0;
    end else if (locked_o && !match) begin
      err_cnt_o <= err_cnt_o + 1'b1;
    end
  end

endmodule

// ==== adc_unit/adc_gearbox.sv ====
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_gearbox (
  input  logic                          fclk,
  input  logic                          rst,
  input  adc_capture_pkg::lane_nibbles_t din_i,
  input  adc_capture_pkg::phase_t       phase_i,
  input  logic                          locked_i,
  output adc_capture_pkg::sample_word_t smp_o,
  output logic                          smp_we_o
);

  // Previous nibble of every lane, the older half of the 8-bit window
  adc_capture_pkg::lane_nibbles_t din_prev;
  adc_capture_pkg::sample_word_t  word;
  logic                           word_done;

  // Pull the 5 frame bits ending at serial index 4-p of the current nibble.
  // In the window {prev, cur} that last bit lands at index p-1
  function automatic adc_capture_pkg::lane_bits_t pick_frame(
    input logic [3:0]              prev,
    input logic [3:0]              cur,
    input adc_capture_pkg::phase_t p
  );
    logic [7:0] window;
    logic [7:0] shifted;
    window  = {prev, cur};
    shifted = window >> (p - 1'b1);
    return shifted[`ADC_FRAME_BITS-1:0];
  endfunction

  always_comb begin
    // Phase 0 puts the frame end past the nibble, so no word this cycle
    word_done = (phase_i != '0);
    for (int c = 0; c < `ADC_NUM_CH; c++) begin
      word.ch[c] = {pick_frame(din_prev.ch[c].a, din_i.ch[c].a, phase_i),
                    pick_frame(din_prev.ch[c].b, din_i.ch[c].b, phase_i)};
    end
  end

  always_ff @(posedge fclk) begin
    din_prev <= din_i;
    if (word_done) begin
      smp_o <= word;
    end
  end

  always_ff @(posedge fclk) begin
    if (rst) begin
      smp_we_o <= 1'b0;
    end else begin
      smp_we_o <= word_done && locked_i;
    end
  end

endmodule

// ==== common/adc_capture_macros.svh ====
`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

`define ADC_NUM_CH      4
`define ADC_FRAME_BITS  5
`define ADC_SAMPLE_W    10
`define ADC_FIFO_DEPTH  8
`define ADC_CREDIT_INIT 4
`define ADC_LOCK_CNT    8

// Register map, word addresses on the 3-bit bus
`define ADC_REG_CTRL   3'd0
`define ADC_REG_STATUS 3'd1
`define ADC_REG_ERRCNT 3'd2
`define ADC_REG_SMPCNT 3'd3
`define ADC_REG_OVFCNT 3'd4

`endif

// ==== common/adc_capture_pkg.sv ====
`include "adc_capture_macros.svh"

package adc_capture_pkg;

  // Position within the 5-bit frame of the first serial bit of a cycle
  typedef logic [2:0] phase_t;

  // One lane's share of a sample
  typedef logic [`ADC_FRAME_BITS-1:0] lane_bits_t;

  // Nibbles of one channel, first serial bit in bit 3
  // Lane a carries sample bits 9..5, lane b bits 4..0
  typedef struct packed {
    logic [3:0] a;
    logic [3:0] b;
  } ch_nibbles_t;

  // All data lanes for one fclk cycle
  typedef struct packed {
    ch_nibbles_t [`ADC_NUM_CH-1:0] ch;
  } lane_nibbles_t;

  // One sample per channel, channel 0 in the low bits
  typedef struct packed {
    logic [`ADC_NUM_CH-1:0][`ADC_SAMPLE_W-1:0] ch;
  } sample_word_t;

  // CTRL register layout
  typedef struct packed {
    logic [28:0] rsvd;
    logic        realign;     // self-clearing
    logic        err_clr;     // self-clearing
    logic        capture_en;
  } ctrl_fields_t;

  // CTRL seen as a bus word or as fields
  typedef union packed {
    ctrl_fields_t f;
    logic [31:0]  raw;
  } ctrl_word_u;

endpackage

// ==== rtl/adc_capture_top.sv ====
`timescale 1ns/1ps

module adc_capture_top (
  input  logic                           fclk,
  input  logic                           rst,
  input  adc_capture_pkg::lane_nibbles_t din_i,
  input  logic [3:0]                     frame_i,
  input  logic                           sync_i,
  input  logic                           bus_stb_i,
  input  logic                           bus_we_i,
  input  logic [2:0]                     bus_adr_i,
  input  logic [31:0]                    bus_dat_i,
  output logic [31:0]                    bus_dat_o,
  output logic                           bus_ack_o,
  output adc_capture_pkg::sample_word_t  smp_o,
  output logic                           smp_valid_o,
  input  logic                           credit_i
);

  adc_capture_pkg::phase_t       phase;
  adc_capture_pkg::sample_word_t gb_smp;
  logic                          locked;
  logic [31:0]                   err_cnt;
  logic                          gb_we;
  logic                          ovf;
  logic                          capture_en;
  logic                          realign;
  logic                          err_clr;
  logic                          sync_meta;
  logic                          sync_q;
  logic                          sync_d;
  logic                          sync_rise;
  logic                          armed;
  logic                          fifo_wr;

  adc_frame_align u_align (
    .fclk      (fclk),
    .rst       (rst),
    .frame_i   (frame_i),
    .realign_i (realign),
    .err_clr_i (err_clr),
    .phase_o   (phase),
    .locked_o  (locked),
    .err_cnt_o (err_cnt)
  );

  adc_gearbox u_gearbox (
    .fclk     (fclk),
    .rst      (rst),
    .din_i    (din_i),
    .phase_i  (phase),
    .locked_i (locked),
    .smp_o    (gb_smp),
    .smp_we_o (gb_we)
  );

  // Sync is asynchronous, two stages then an edge register
  always_ff @(posedge fclk) begin
    sync_meta <= sync_i;
    sync_q    <= sync_meta;
    sync_d    <= sync_q;
  end

  assign sync_rise = sync_q && !sync_d;

  always_ff @(posedge fclk) begin
    if (rst) begin
      armed <= 1'b0;
    end else if (realign || !capture_en || !locked) begin
      armed <= 1'b0;
    end else if (sync_rise) begin
      armed <= 1'b1;
    end
  end

  assign fifo_wr = gb_we && armed;

  sample_fifo u_fifo (
    .fclk     (fclk),
    .rst      (rst),
    .wr_i     (fifo_wr),
    .data_i   (gb_smp),
    .credit_i (credit_i),
    .data_o   (smp_o),
    .valid_o  (smp_valid_o),
    .ovf_o    (ovf)
  );

  adc_reg_attach u_regs (
    .fclk          (fclk),
    .rst           (rst),
    .bus_stb_i     (bus_stb_i),
    .bus_we_i      (bus_we_i),
    .bus_adr_i     (bus_adr_i),
    .bus_dat_i     (bus_dat_i),
    .bus_dat_o     (bus_dat_o),
    .bus_ack_o     (bus_ack_o),
    .locked_i      (locked),
    .armed_i       (armed),
    .err_cnt_i     (err_cnt),
    .smp_cnt_inc_i (smp_valid_o),
    .ovf_i         (ovf),
    .capture_en_o  (capture_en),
    .realign_o     (realign),
    .err_clr_o     (err_clr)
  );

endmodule

// ==== rtl/adc_reg_attach.sv ====
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_reg_attach (
  input  logic        fclk,
  input  logic        rst,
  input  logic        bus_stb_i,
  input  logic        bus_we_i,
  input  logic [2:0]  bus_adr_i,
  input  logic [31:0] bus_dat_i,
  output logic [31:0] bus_dat_o,
  output logic        bus_ack_o,
  input  logic        locked_i,
  input  logic        armed_i,
  input  logic [31:0] err_cnt_i,
  input  logic        smp_cnt_inc_i,
  input  logic        ovf_i,
  output logic        capture_en_o,
  output logic        realign_o,
  output logic        err_clr_o
);

  adc_capture_pkg::ctrl_word_u wr_word;
  adc_capture_pkg::ctrl_word_u ctrl_rd;
  logic                        ctrl_wr;
  logic [31:0]                 smp_cnt;
  logic [31:0]                 ovf_cnt;
  logic [31:0]                 rd_data;

  assign ctrl_wr = bus_stb_i && bus_we_i && (bus_adr_i == `ADC_REG_CTRL);

  always_comb begin
    wr_word.raw = bus_dat_i;
    // Only capture_en reads back, the strobes read as zero
    ctrl_rd.raw          = '0;
    ctrl_rd.f.capture_en = capture_en_o;
  end

  always_comb begin
    case (bus_adr_i)
      `ADC_REG_CTRL:   rd_data = ctrl_rd.raw;
      `ADC_REG_STATUS: rd_data = {30'd0, armed_i, locked_i};
      `ADC_REG_ERRCNT: rd_data = err_cnt_i;
      `ADC_REG_SMPCNT: rd_data = smp_cnt;
      `ADC_REG_OVFCNT: rd_data = ovf_cnt;
      default:         rd_data = '0;
    endcase
  end

  always_ff @(posedge fclk) begin
    if (rst) begin
      bus_ack_o    <= 1'b0;
      capture_en_o <= 1'b0;
      realign_o    <= 1'b0;
      err_clr_o    <= 1'b0;
    end else begin
      bus_ack_o <= bus_stb_i;
      realign_o <= ctrl_wr && wr_word.f.realign;
      err_clr_o <= ctrl_wr && wr_word.f.err_clr;
      if (ctrl_wr) begin
        capture_en_o <= wr_word.f.capture_en;
      end
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge fclk) begin
    if (bus_stb_i && !bus_we_i) begin
      bus_dat_o <= rd_data;
    end
  end

  always_ff @(posedge fclk) begin
    if (rst) begin
      smp_cnt <= '0;
      ovf_cnt <= '0;
    end else begin
      if (smp_cnt_inc_i) begin
        smp_cnt <= smp_cnt + 1'b1;
      end
      if (ovf_i) begin
        ovf_cnt <= ovf_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module sample_fifo (
  input  logic                          fclk,
  input  logic                          rst,
  input  logic                          wr_i,
  input  adc_capture_pkg::sample_word_t data_i,
  input  logic                          credit_i,
  output adc_capture_pkg::sample_word_t data_o,
  output logic                          valid_o,
  output logic                          ovf_o
);

  localparam int DEPTH = `ADC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`ADC_CREDIT_INIT + 1);

  adc_capture_pkg::sample_word_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  logic             full;
  logic             push;
  logic             pop;

  assign full  = (count == CNT_W'(DEPTH));
  assign push  = wr_i && !full;
  assign pop   = (count != '0) && (credits != '0);
  // Word offered to a full buffer is lost
  assign ovf_o = wr_i && full;

  always_ff @(posedge fclk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
    if (pop) begin
      data_o <= mem[rd_ptr];
    end
  end

  always_ff @(posedge fclk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRD_W'(`ADC_CREDIT_INIT);
      valid_o <= 1'b0;
    end else begin
      valid_o <= pop;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Spend on send, refill on return
      case ({pop, credit_i})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ADC capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module adc_capture_tb \
  -f adc_capture_top.f \
  -o adc_capture_sim

./obj_dir/adc_capture_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"
exit 0

// ==== test/adc_capture_checker.sv ====
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_capture_checker (
  input  logic                          fclk,
  input  adc_capture_pkg::sample_word_t smp_i,
  input  logic                          smp_valid_i,
  input  logic                          credit_i,
  input  logic                          mdl_we_i,
  input  adc_capture_pkg::sample_word_t mdl_word_i,
  input  logic                          align_i,
  input  logic                          gap_i,
  input  int                            test_i,
  input  logic                          rc_stb_i,
  input  logic [31:0]                   rc_exp_i,
  input  logic [31:0]                   rc_act_i,
  output int                            n_err_o,
  output int                            n_match_o,
  output int                            n_valid_o,
  output int                            n_gap_o
);

  adc_capture_pkg::sample_word_t exp_q[$];
  int                            credits_back;
  // In-order words since the last alignment, zero once a gap was taken
  int                            run;

  function automatic string test_name(input int id);
    case (id)
      0:       return "lock";
      1:       return "credit_flow";
      2:       return "frame_errors";
      3:       return "realign";
      4:       return "back_pressure";
      5:       return "sample_count";
      default: return "unknown";
    endcase
  endfunction

  initial begin
    n_err_o      = 0;
    n_match_o    = 0;
    n_valid_o    = 0;
    n_gap_o      = 0;
    credits_back = 0;
    run          = 0;
  end

  always @(posedge fclk) begin : compare
    int skipped;
    if (mdl_we_i) begin
      exp_q.push_back(mdl_word_i);
    end
    if (credit_i) begin
      credits_back++;
    end
    if (rc_stb_i && rc_exp_i != rc_act_i) begin
      $display("Error: %s expected %h actual %h", test_name(test_i), rc_exp_i, rc_act_i);
      n_err_o++;
    end
    if (smp_valid_i) begin
      n_valid_o++;
      if (n_valid_o > credits_back + `ADC_CREDIT_INIT) begin
        $display("%s: a sample went out without a credit (%0d sent, %0d credits)",
                 test_name(test_i), n_valid_o, credits_back + `ADC_CREDIT_INIT);
        n_err_o++;
      end
      if (exp_q.size() == 0) begin
        $display("%s: a sample arrived but the model produced none", test_name(test_i));
        n_err_o++;
      end else if (exp_q[0] == smp_i) begin
        void'(exp_q.pop_front());
        n_match_o++;
        if (run > 0) begin
          run++;
        end
      end else if (align_i ||
                   (gap_i && run == `ADC_CREDIT_INIT + `ADC_FIFO_DEPTH)) begin
        // Words the DUT never stored are skipped
        // An overflow gap only follows the words covered by credits and the FIFO
        skipped = 0;
        while (exp_q.size() > 0 && exp_q[0] != smp_i) begin
          void'(exp_q.pop_front());
          skipped++;
        end
        if (exp_q.size() == 0) begin
          $display("%s: delivered sample %h is not in the model stream",
                   test_name(test_i), smp_i);
          n_err_o++;
        end else begin
          void'(exp_q.pop_front());
          n_match_o++;
          if (align_i) begin
            run = 1;
          end else begin
            n_gap_o += skipped;
            run = 0;
          end
        end
      end else begin
        $display("Error: %s expected %h actual %h", test_name(test_i), exp_q[0], smp_i);
        void'(exp_q.pop_front());
        n_err_o++;
      end
    end
  end

endmodule

// ==== test/adc_capture_sva.sv ====
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_capture_sva #(
  parameter int CRD_W = 3
) (
  input logic             fclk,
  input logic             rst,
  input logic             valid_o,
  input logic             credit_i,
  input logic [CRD_W-1:0] credits,
  input logic             bus_stb_i,
  input logic             bus_ack_o
);

  // Credits granted at the ports and not yet spent by a send
  logic [CRD_W-1:0] avail;

  always_ff @(posedge fclk) begin
    if (rst) begin
      avail <= CRD_W'(`ADC_CREDIT_INIT);
    end else begin
      case ({valid_o, credit_i})
        2'b10:   avail <= avail - 1'b1;
        2'b01:   avail <= avail + 1'b1;
        default: avail <= avail;
      endcase
    end
  end

  a_send_needs_credit: assert property (@(posedge fclk) disable iff (rst)
    valid_o |-> avail != '0)
    else $error("FIFO sent a word while holding no credit");

  a_credit_bound: assert property (@(posedge fclk) disable iff (rst)
    credits <= CRD_W'(`ADC_CREDIT_INIT))
    else $error("FIFO credit count above its initial value");

  a_ack_follows_stb: assert property (@(posedge fclk) disable iff (rst)
    bus_stb_i |=> bus_ack_o)
    else $error("Bus ack missing one cycle after stb");

  a_ack_needs_stb: assert property (@(posedge fclk) disable iff (rst)
    bus_ack_o |-> $past(bus_stb_i))
    else $error("Bus ack without stb in the previous cycle");

endmodule

// FIFO rules checked through the instance inside the top level
bind adc_capture_top adc_capture_sva #(.CRD_W($clog2(`ADC_CREDIT_INIT + 1))) u_sva (
  .fclk      (fclk),
  .rst       (rst),
  .valid_o   (u_fifo.valid_o),
  .credit_i  (credit_i),
  .credits   (u_fifo.credits),
  .bus_stb_i (bus_stb_i),
  .bus_ack_o (bus_ack_o)
);

// ==== test/adc_capture_tb.sv ====
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_capture_tb;

  // Run lengths in cycles
  localparam int LOCK_RUN    = 200;
  localparam int CREDIT_RUN  = 300;
  localparam int STALL_RUN   = 40;
  localparam int DRAIN_RUN   = 80;
  localparam int REALIGN_RUN = 150;
  localparam int BUS_BUDGET  = 400;
  localparam int TEST_CYCLES = LOCK_RUN + CREDIT_RUN + STALL_RUN + 4 * DRAIN_RUN
                               + REALIGN_RUN + BUS_BUDGET;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                          fclk;
  logic                          rst;
  adc_capture_pkg::lane_nibbles_t din;
  logic [3:0]                    frame;
  logic                          sync;
  logic                          bus_stb;
  logic                          bus_we;
  logic [2:0]                    bus_adr;
  logic [31:0]                   bus_dat_w;
  logic [31:0]                   bus_dat_r;
  logic                          bus_ack;
  adc_capture_pkg::sample_word_t smp;
  logic                          smp_valid;
  logic                          credit;

  // Serial ADC model state
  logic [31:0]                   rng;
  logic [31:0]                   crd_rng;
  int                            pos;
  adc_capture_pkg::sample_word_t cur;
  logic                          bad;
  logic                          mdl_we;
  adc_capture_pkg::sample_word_t mdl_word;
  logic                          corrupt_req;
  logic                          slip_req;
  int                            crd_mode;
  int                            outstanding;

  // Checker control and results
  logic        align;
  logic        gap;
  int          cur_test;
  logic        rc_stb;
  logic [31:0] rc_exp;
  logic [31:0] rc_act;
  int          n_err;
  int          n_match;
  int          n_valid;
  int          n_gap;
  int          n_fail;

  adc_capture_top uut (
    .fclk        (fclk),
    .rst         (rst),
    .din_i       (din),
    .frame_i     (frame),
    .sync_i      (sync),
    .bus_stb_i   (bus_stb),
    .bus_we_i    (bus_we),
    .bus_adr_i   (bus_adr),
    .bus_dat_i   (bus_dat_w),
    .bus_dat_o   (bus_dat_r),
    .bus_ack_o   (bus_ack),
    .smp_o       (smp),
    .smp_valid_o (smp_valid),
    .credit_i    (credit)
  );

  adc_capture_checker chk (
    .fclk        (fclk),
    .smp_i       (smp),
    .smp_valid_i (smp_valid),
    .credit_i    (credit),
    .mdl_we_i    (mdl_we),
    .mdl_word_i  (mdl_word),
    .align_i     (align),
    .gap_i       (gap),
    .test_i      (cur_test),
    .rc_stb_i    (rc_stb),
    .rc_exp_i    (rc_exp),
    .rc_act_i    (rc_act),
    .n_err_o     (n_err),
    .n_match_o   (n_match),
    .n_valid_o   (n_valid),
    .n_gap_o     (n_gap)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    fclk = 1'b0;
    forever #5 fclk = ~fclk;
  end

  // Four serial bits per lane each cycle, frame marker on a frame's first bit
  always @(posedge fclk) begin : model_step
    logic take_slip;
    logic take_corrupt;
    take_slip    = slip_req;
    take_corrupt = corrupt_req;
    #1;
    mdl_we = 1'b0;
    if (take_slip) begin
      // Drop one serial bit, the broken frame is never expected
      slip_req = 1'b0;
      bad      = 1'b1;
      pos      = (pos == 4) ? 0 : pos + 1;
    end
    for (int k = 0; k < 4; k++) begin
      if (pos == 0) begin
        for (int c = 0; c < `ADC_NUM_CH; c++) begin
          rng       = xorshift32(rng);
          cur.ch[c] = rng[9:0];
        end
        bad = 1'b0;
      end
      frame[3-k] = (pos == 0);
      for (int c = 0; c < `ADC_NUM_CH; c++) begin
        din.ch[c].a[3-k] = cur.ch[c][9-pos];
        din.ch[c].b[3-k] = cur.ch[c][4-pos];
      end
      if (pos == 4 && !bad) begin
        mdl_we   = 1'b1;
        mdl_word = cur;
      end
      pos = (pos == 4) ? 0 : pos + 1;
    end
    if (take_corrupt) begin
      corrupt_req = 1'b0;
      frame       = ~frame;
    end
  end

  // Credit return: 0 withholds, 1 random, 2 as fast as possible
  always @(posedge fclk) begin : credit_return
    logic give;
    if (smp_valid) begin
      outstanding++;
    end
    crd_rng = xorshift32(crd_rng);
    give = (outstanding > 0) &&
           ((crd_mode == 2) || (crd_mode == 1 && crd_rng[2:0] != 3'b000));
    if (give) begin
      outstanding--;
    end
    #1;
    credit = give;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge fclk);
    #1;
  endtask

  task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
    rc_exp = exp;
    rc_act = act;
    rc_stb = 1'b1;
    wait_cycles(1);
    rc_stb = 1'b0;
  endtask

  task automatic note_failure(input string what);
    $display("%s", what);
    n_fail++;
  endtask

  task automatic bus_access(input logic we, input logic [2:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    bus_stb   = 1'b1;
    bus_we    = we;
    bus_adr   = adr;
    bus_dat_w = wdat;
    wait_cycles(1);
    bus_stb = 1'b0;
    bus_we  = 1'b0;
    waited  = 0;
    while (!bus_ack && waited < 4) begin
      wait_cycles(1);
      waited++;
    end
    rdat = bus_dat_r;
    if (!bus_ack) begin
      note_failure("Bus access got no ack after the strobe");
    end
    wait_cycles(1);
  endtask

  task automatic bus_write(input logic [2:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_access(1'b1, adr, wdat, unused);
  endtask

  task automatic bus_read(input logic [2:0] adr, output logic [31:0] rdat);
    bus_access(1'b0, adr, 32'd0, rdat);
  endtask

  task automatic wait_locked();
    logic [31:0] st;
    int          tries;
    st    = '0;
    tries = 0;
    while (!st[0] && tries < 40) begin
      bus_read(`ADC_REG_STATUS, st);
      tries++;
    end
    if (!st[0]) begin
      note_failure("The frame aligner never reported lock");
    end
  endtask

  task automatic wait_match();
    int m0;
    int tries;
    m0    = n_match;
    tries = 0;
    while (n_match == m0 && tries < 60) begin
      wait_cycles(1);
      tries++;
    end
    if (n_match == m0) begin
      note_failure("No delivered sample matched the model stream");
    end
  endtask

  task automatic pulse_sync();
    sync = 1'b1;
    wait_cycles(3);
    sync = 1'b0;
    wait_cycles(3);
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%s: finished, %0d errors", name, n_err + n_fail - err0);
  endtask

  initial begin : main
    logic [31:0] rd;
    logic [31:0] ovf0;
    int          gap0;
    int          err0;
    rst         = 1'b1;
    sync        = 1'b0;
    bus_stb     = 1'b0;
    bus_we      = 1'b0;
    bus_adr     = '0;
    bus_dat_w   = '0;
    credit      = 1'b0;
    din         = '0;
    frame       = '0;
    rng         = 32'h97ae_9eeb;
    crd_rng     = xorshift32(32'h97ae_9eeb);
    pos         = int'(rng % 5);
    cur         = '0;
    bad         = 1'b1;
    mdl_we      = 1'b0;
    mdl_word    = '0;
    corrupt_req = 1'b0;
    slip_req    = 1'b0;
    crd_mode    = 1;
    outstanding = 0;
    align       = 1'b0;
    gap         = 1'b0;
    cur_test    = 0;
    rc_stb      = 1'b0;
    rc_exp      = '0;
    rc_act      = '0;
    n_fail      = 0;
    repeat (4) @(posedge fclk);
    #1;
    rst = 1'b0;

    // Lock and arm, then samples follow the model in order
    err0 = n_err + n_fail;
    bus_write(`ADC_REG_CTRL, 32'h1);
    wait_locked();
    align = 1'b1;
    pulse_sync();
    bus_read(`ADC_REG_STATUS, rd);
    check_value(32'h3, rd);
    wait_match();
    align = 1'b0;
    wait_cycles(LOCK_RUN);
    report_test("lock", err0);

    // Random credit returns, nothing may overflow
    cur_test = 1;
    err0     = n_err + n_fail;
    bus_read(`ADC_REG_OVFCNT, ovf0);
    wait_cycles(CREDIT_RUN);
    bus_read(`ADC_REG_OVFCNT, rd);
    check_value(ovf0, rd);
    report_test("credit_flow", err0);

    // Single-cycle marker corruption
    cur_test = 2;
    err0     = n_err + n_fail;
    bus_write(`ADC_REG_CTRL, 32'h3);
    bus_read(`ADC_REG_ERRCNT, rd);
    check_value(32'd0, rd);
    for (int i = 0; i < 5; i++) begin
      corrupt_req = 1'b1;
      wait_cycles(6);
    end
    bus_read(`ADC_REG_ERRCNT, rd);
    check_value(32'd5, rd);
    bus_read(`ADC_REG_STATUS, rd);
    check_value(32'h3, rd);
    bus_write(`ADC_REG_CTRL, 32'h3);
    bus_read(`ADC_REG_ERRCNT, rd);
    check_value(32'd0, rd);
    report_test("frame_errors", err0);

    // Realign, shift the stream, relock
    cur_test = 3;
    err0     = n_err + n_fail;
    crd_mode = 2;
    bus_write(`ADC_REG_CTRL, 32'h5);
    slip_req = 1'b1;
    bus_read(`ADC_REG_STATUS, rd);
    check_value(32'h0, rd);
    wait_cycles(30);
    wait_locked();
    align = 1'b1;
    pulse_sync();
    bus_read(`ADC_REG_STATUS, rd);
    check_value(32'h3, rd);
    wait_match();
    align = 1'b0;
    wait_cycles(REALIGN_RUN);
    report_test("realign", err0);

    // Withhold credits until the FIFO overflows
    cur_test = 4;
    err0     = n_err + n_fail;
    bus_write(`ADC_REG_CTRL, 32'h0);
    wait_cycles(DRAIN_RUN);
    bus_read(`ADC_REG_OVFCNT, ovf0);
    gap0     = n_gap;
    crd_mode = 0;
    align    = 1'b1;
    bus_write(`ADC_REG_CTRL, 32'h1);
    pulse_sync();
    wait_match();
    align = 1'b0;
    gap   = 1'b1;
    wait_cycles(STALL_RUN);
    crd_mode = 2;
    wait_cycles(DRAIN_RUN);
    gap = 1'b0;
    bus_read(`ADC_REG_OVFCNT, rd);
    check_value(ovf0 + 32'(n_gap - gap0), rd);
    if (rd <= ovf0) begin
      note_failure("No overflow was counted while credits were withheld");
    end
    report_test("back_pressure", err0);

    // Delivered sample counter
    cur_test = 5;
    err0     = n_err + n_fail;
    bus_write(`ADC_REG_CTRL, 32'h0);
    wait_cycles(DRAIN_RUN);
    bus_read(`ADC_REG_SMPCNT, rd);
    check_value(32'(n_valid), rd);
    report_test("sample_count", err0);

    wait_cycles(2);
    $display("samples %0d, matched %0d, errors %0d", n_valid, n_match, n_err + n_fail);
    if (n_err + n_fail == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge fclk);
    $display("Watchdog expired after %0d cycles, the run is stuck", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule
